/* include/red_settings.svh */
/*
 * Reduction stage settings
 * Route count, payload width and the switch for the
 * parallel reduction operators
 */

`ifndef RED_SETTINGS_SVH
`define RED_SETTINGS_SVH

// --------------------
// Geometry
// --------------------

// Local, north, east, south and west
`define RED_NUM_ROUTES 5

// Plain payload word, response sits in bits 1:0
`define RED_DATA_W 32

// --------------------
// Features
// --------------------

// Forward and LSB-AND operators, 0 turns them into a zero flit
`define RED_EN_PARALLEL 1

`endif

/* logic/red_flit_pkg.sv */
/*
 * Flit content types
 * Collective opcodes, response codes, header, payload and
 * the complete flit seen on every route
 */

package red_flit_pkg;

  `include "red_settings.svh"

  // --------------------
  // Encodings
  // --------------------

  // Collective operation carried in the header
  typedef enum logic [1:0] {
    OP_NONE      = 2'd0,
    OP_SELECT_AW = 2'd1,
    OP_LSB_AND   = 2'd2,
    OP_COLLECT_B = 2'd3
  } collective_op_e;

  // Response code, same ordering as the AXI B channel
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  // --------------------
  // Flit layout
  // --------------------

  // Payload word, response in the two low bits
  typedef logic [`RED_DATA_W-1:0] red_payload_t;

  // Opcode and the routes expected to join
  typedef struct packed {
    collective_op_e              collective_op;
    logic [`RED_NUM_ROUTES-1:0]  src_mask;
  } red_hdr_t;

  typedef struct packed {
    red_hdr_t     hdr;
    red_payload_t payload;
  } red_flit_t;

endpackage

/* logic/red_route_pkg.sv */
/*
 * Route bookkeeping types
 * Route numbering, per-route masks and indices, and the
 * state of the output register
 */

package red_route_pkg;

  `include "red_settings.svh"

  // Route numbering, also the priority order of the scan
  typedef enum logic [2:0] {
    ROUTE_LOCAL = 3'd0,
    ROUTE_NORTH = 3'd1,
    ROUTE_EAST  = 3'd2,
    ROUTE_SOUTH = 3'd3,
    ROUTE_WEST  = 3'd4
  } route_e;

  // One bit per route
  typedef logic [`RED_NUM_ROUTES-1:0] route_mask_t;

  // Index wide enough for every route
  typedef logic [2:0] route_idx_t;

  // One-entry output register occupancy
  typedef enum logic {
    OUT_EMPTY = 1'b0,
    OUT_FULL  = 1'b1
  } out_state_e;

endpackage

/* logic/red_sync_decode.sv */
/*
 * Reduction sync and decode
 * Finds the first valid route, takes opcode and participant
 * mask from its header and flags when every participant
 * has a flit waiting
 */

`timescale 1ns/1ps

`include "red_settings.svh"

module red_sync_decode (
  input  red_route_pkg::route_mask_t                      valid_i,
  input  red_flit_pkg::red_flit_t [`RED_NUM_ROUTES-1:0]   data_i,
  output red_route_pkg::route_idx_t                       sel_o,
  output red_flit_pkg::collective_op_e                    op_o,
  output red_route_pkg::route_mask_t                      mask_o,
  output logic                                            sync_valid_o
);

  import red_flit_pkg::*;
  import red_route_pkg::*;

  route_idx_t  sel;
  logic        any_valid;
  red_flit_t   sel_flit;
  route_mask_t mask;
  logic        all_present;
  logic        sel_in_mask;

  // --------------------
  // First valid route
  // --------------------

  // Priority scan, lowest index wins, same result as a
  // trailing-zero count on the valid vector
  always_comb begin : scan_first
    sel       = route_idx_t'(ROUTE_LOCAL);
    any_valid = 1'b0;
    for (int i = 0; i < `RED_NUM_ROUTES; i++) begin
      if (valid_i[i] && !any_valid) begin
        sel       = route_idx_t'(i);
        any_valid = 1'b1;
      end
    end
  end

  // Header of the leading flit drives the whole reduction
  assign sel_flit = data_i[sel];
  assign mask     = sel_flit.hdr.src_mask;

  // --------------------
  // Synchronisation
  // --------------------

  // Every masked route must offer a flit
  assign all_present = ((valid_i & mask) == mask);

  // Leading route has to be a participant itself
  assign sel_in_mask = mask[sel];

  // Empty mask or a leader outside the mask stalls forever
  // rather than producing a bogus result
  assign sync_valid_o = any_valid && (mask != '0) && all_present && sel_in_mask;

  assign sel_o  = sel;
  assign op_o   = sel_flit.hdr.collective_op;
  assign mask_o = mask;

endmodule

/* logic/red_op_execute.sv */
/*
 * Reduction operators
 * Forward, LSB-AND and Collect-B are computed side by side
 * and the opcode of the leading flit picks one of them
 */

`timescale 1ns/1ps

`include "red_settings.svh"

module red_op_execute (
  input  red_flit_pkg::red_flit_t [`RED_NUM_ROUTES-1:0]   data_i,
  input  red_route_pkg::route_idx_t                       sel_i,
  input  red_flit_pkg::collective_op_e                    op_i,
  input  red_route_pkg::route_mask_t                      mask_i,
  output red_flit_pkg::red_flit_t                         red_o
);

  import red_flit_pkg::*;

  // Forward and LSB-AND only exist with parallel reduction on
  localparam bit EnParallel = `RED_EN_PARALLEL;

  red_flit_t fwd_flit;
  red_flit_t lsb_flit;
  red_flit_t collb_flit;

  // --------------------
  // Forward
  // --------------------

  // Leading flit passes untouched
  assign fwd_flit = EnParallel ? data_i[sel_i] : '0;

  // --------------------
  // LSB-AND
  // --------------------

  always_comb begin : gen_lsb_and
    red_payload_t word;
    logic         lsb;
    lsb_flit = '0;
    word     = '0;
    lsb      = 1'b1;
    if (EnParallel) begin
      lsb_flit = data_i[sel_i];
      // Fold bit 0 of every participant
      for (int i = 0; i < `RED_NUM_ROUTES; i++) begin
        if (mask_i[i]) begin
          word = data_i[i].payload;
          lsb  = lsb & word[0];
        end
      end
      // Leader keeps its header and upper payload bits
      lsb_flit.payload[0] = lsb;
    end
  end

  // --------------------
  // Collect-B
  // --------------------

  // First SLVERR in index order, else the leading flit
  always_comb begin : gen_collect_b
    logic found;
    collb_flit = data_i[sel_i];
    found      = 1'b0;
    for (int i = 0; i < `RED_NUM_ROUTES; i++) begin
      if (mask_i[i] && !found) begin
        if (resp_e'(data_i[i].payload[1:0]) == RESP_SLVERR) begin
          collb_flit = data_i[i];
          found      = 1'b1;
        end
      end
    end
  end

  // Opcode select, OP_NONE gives a zero flit
  always_comb begin : sel_result
    case (op_i)
      OP_SELECT_AW: red_o = fwd_flit;
      OP_LSB_AND:   red_o = lsb_flit;
      OP_COLLECT_B: red_o = collb_flit;
      default:      red_o = '0;
    endcase
  end

endmodule

/* logic/red_result_stage.sv */
/*
 * Reduction output register
 * Single entry holding the reduced flit; loads when all
 * participants are present and there is room, and pops the
 * participating inputs in that same cycle
 */

`timescale 1ns/1ps

module red_result_stage (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        sync_valid_i,
  input  red_route_pkg::route_mask_t  mask_i,
  input  red_route_pkg::route_mask_t  valid_i,
  input  red_flit_pkg::red_flit_t     red_i,
  output red_route_pkg::route_mask_t  ready_o,
  output logic                        valid_o,
  input  logic                        ready_i,
  output red_flit_pkg::red_flit_t     data_o
);

  import red_flit_pkg::*;
  import red_route_pkg::*;

  out_state_e state_q;
  red_flit_t  data_q;
  logic       drain;
  logic       load;

  // --------------------
  // Handshake
  // --------------------

  // Output flit accepted downstream this cycle
  assign drain = (state_q == OUT_FULL) && ready_i;

  // Room when empty or emptying, so full throughput
  // with ready_i held high
  assign load = sync_valid_i && ((state_q == OUT_EMPTY) || drain);

  // Release only the routes that took part
  assign ready_o = load ? (mask_i & valid_i) : '0;

  // --------------------
  // Occupancy
  // --------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= OUT_EMPTY;
    end else if (load) begin
      state_q <= OUT_FULL;
    end else if (drain) begin
      state_q <= OUT_EMPTY;
    end
  end

  // Payload register, held under back-pressure
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= red_i;
    end
  end

  assign valid_o = (state_q == OUT_FULL);
  assign data_o  = data_q;

endmodule

/* logic/red_reduction_top.sv */
/*
 * Reduction stage top
 * Decode, operators and output register of one mesh router
 * reduction stage, wired together
 */

`timescale 1ns/1ps

`include "red_settings.svh"

module red_reduction_top (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  red_route_pkg::route_mask_t                      valid_i,
  output red_route_pkg::route_mask_t                      ready_o,
  input  red_flit_pkg::red_flit_t [`RED_NUM_ROUTES-1:0]   data_i,
  output logic                                            valid_o,
  input  logic                                            ready_i,
  output red_flit_pkg::red_flit_t                         data_o
);

  import red_flit_pkg::*;
  import red_route_pkg::*;

  route_idx_t     sel;
  collective_op_e op;
  route_mask_t    mask;
  logic           sync_valid;
  red_flit_t      red;

  // Leader selection and participant sync
  red_sync_decode u_decode (
    .valid_i      (valid_i),
    .data_i       (data_i),
    .sel_o        (sel),
    .op_o         (op),
    .mask_o       (mask),
    .sync_valid_o (sync_valid)
  );

  // Combinational reduction
  red_op_execute u_execute (
    .data_i (data_i),
    .sel_i  (sel),
    .op_i   (op),
    .mask_i (mask),
    .red_o  (red)
  );

  // One cycle of latency lives here
  red_result_stage u_result (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .sync_valid_i (sync_valid),
    .mask_i       (mask),
    .valid_i      (valid_i),
    .red_i        (red),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .data_o       (data_o)
  );

endmodule

/* tb/red_tb.sv */
/*
 * Reduction stage testbench
 * Applies a table of collective flits to the five routes,
 * throttles the output with LFSR back-pressure and checks
 * the pop pattern and every reduced flit
 */

`timescale 1ns/1ps

`include "red_settings.svh"

module red_tb;

  import red_flit_pkg::*;
  import red_route_pkg::*;

  localparam int TIMEOUT = 100;

  // One table row with the hand-computed result
  typedef struct packed {
    collective_op_e                                op;
    route_mask_t                                   mask;
    route_mask_t                                   vld;
    route_mask_t                                   late;
    logic                                          hold;
    logic [`RED_NUM_ROUTES-1:0][`RED_DATA_W-1:0]   pay;
    red_flit_t                                     exp;
  } row_t;

  logic                                   clk_i;
  logic                                   rst_i;
  route_mask_t                            valid_i;
  route_mask_t                            ready_o;
  red_flit_t [`RED_NUM_ROUTES-1:0]        data_i;
  logic                                   valid_o;
  logic                                   ready_i = 1'b0;
  red_flit_t                              data_o;

  row_t        rows[$];
  red_flit_t   exp_q[$];
  int          errors = 0;
  int          mon_errors = 0;
  int          timeouts = 0;
  int          cycle = 0;
  int          hold_end = 0;
  logic [31:0] lfsr = 32'hfa26;
  logic        prev_valid = 1'b0;
  logic        prev_ready = 1'b0;
  red_flit_t   prev_data;

  red_reduction_top u_dut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o)
  );

  initial begin : clock
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic red_flit_t make_flit(input collective_op_e op, input route_mask_t mask,
                                          input logic [`RED_DATA_W-1:0] pay);
    red_flit_t f;
    f.hdr.collective_op = op;
    f.hdr.src_mask      = mask;
    f.payload           = pay;
    return f;
  endfunction

  task automatic check_flit(input string name, input red_flit_t got, input red_flit_t exp,
                            inout int cnt);
    if (got !== exp) begin
      cnt++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_mask(input string name, input route_mask_t got, input route_mask_t exp,
                            inout int cnt);
    if (got !== exp) begin
      cnt++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic add_row(input collective_op_e op, input route_mask_t mask,
                         input route_mask_t vld, input route_mask_t late, input logic hold,
                         input logic [`RED_NUM_ROUTES-1:0][`RED_DATA_W-1:0] pay,
                         input red_flit_t exp);
    rows.push_back('{op, mask, vld, late, hold, pay, exp});
  endtask

  // --------------------
  // Stimulus table
  // --------------------

  // Payloads listed west, south, east, north, local
  task automatic fill_table();
    add_row(OP_NONE, 5'b00011, 5'b00011, 5'b00000, 1'b0,
            {32'h0, 32'h0, 32'h0, 32'h2222_2222, 32'h1111_1111}, '0);
    // Forward between north and east
    add_row(OP_SELECT_AW, 5'b00110, 5'b00110, 5'b00000, 1'b0,
            {32'h0, 32'h0, 32'h9abc_def0, 32'h1234_5678, 32'h0},
            make_flit(OP_SELECT_AW, 5'b00110, 32'h1234_5678));
    // Mixed bit 0 clears the leader LSB
    add_row(OP_LSB_AND, 5'b10101, 5'b10101, 5'b00000, 1'b0,
            {32'h0000_0003, 32'h0, 32'h0000_1110, 32'h0, 32'hcafe_0001},
            make_flit(OP_LSB_AND, 5'b10101, 32'hcafe_0000));
    add_row(OP_LSB_AND, 5'b01011, 5'b01011, 5'b00000, 1'b0,
            {32'h0, 32'hffff_ffff, 32'h0, 32'h0000_0001, 32'h8000_0003},
            make_flit(OP_LSB_AND, 5'b01011, 32'h8000_0003));
    // Single SLVERR on south
    add_row(OP_COLLECT_B, 5'b11100, 5'b11100, 5'b00000, 1'b0,
            {32'hcccc_0001, 32'hbbbb_0002, 32'haaaa_0000, 32'h0, 32'h0},
            make_flit(OP_COLLECT_B, 5'b11100, 32'hbbbb_0002));
    // North beats south and ready_i is then held low
    add_row(OP_COLLECT_B, 5'b11111, 5'b11111, 5'b00000, 1'b1,
            {32'h5000_0001, 32'h4000_0002, 32'h3000_0000, 32'h2000_0002, 32'h1000_0003},
            make_flit(OP_COLLECT_B, 5'b11111, 32'h2000_0002));
    // East carries SLVERR but sits outside the mask
    add_row(OP_COLLECT_B, 5'b00011, 5'b00011, 5'b00000, 1'b0,
            {32'h0, 32'h0, 32'h7777_0002, 32'h6666_0003, 32'h5555_0001},
            make_flit(OP_COLLECT_B, 5'b00011, 32'h5555_0001));
    // West and local arrive late
    add_row(OP_SELECT_AW, 5'b11000, 5'b01000, 5'b10000, 1'b0,
            {32'h8888_8888, 32'h7777_7777, 32'h0, 32'h0, 32'h0},
            make_flit(OP_SELECT_AW, 5'b11000, 32'h7777_7777));
    add_row(OP_LSB_AND, 5'b00101, 5'b00100, 5'b00001, 1'b0,
            {32'h0, 32'h0, 32'hffff_fffe, 32'h0, 32'hffff_ffff},
            make_flit(OP_LSB_AND, 5'b00101, 32'hffff_fffe));
    add_row(OP_NONE, 5'b10000, 5'b10000, 5'b00000, 1'b0,
            {32'h9999_9999, 32'h0, 32'h0, 32'h0, 32'h0}, '0);
  endtask

  // --------------------
  // Waits
  // --------------------

  task automatic wait_pop(output bit ok);
    int n;
    n = 0;
    @(negedge clk_i);
    while (ready_o == '0 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    ok = (ready_o != '0);
    if (!ok) begin
      timeouts++;
      $display("Timeout: the participating inputs were never popped");
    end
  endtask

  // Output register empty and nothing outstanding
  task automatic wait_idle(output bit ok);
    int n;
    n = 0;
    @(negedge clk_i);
    while ((exp_q.size() != 0 || valid_o) && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    ok = (exp_q.size() == 0 && !valid_o);
    if (!ok) begin
      timeouts++;
      $display("Timeout: the output register never drained");
    end
  endtask

  // --------------------
  // Driver
  // --------------------

  task automatic run_row(input row_t row, output bit ok);
    route_mask_t seen;
    ok = 1'b1;
    if (row.late != '0) begin
      wait_idle(ok);
      if (!ok) return;
    end
    @(posedge clk_i);
    valid_i <= row.vld;
    for (int i = 0; i < `RED_NUM_ROUTES; i++) begin
      data_i[i] <= make_flit(row.op, row.mask, row.pay[i]);
    end
    // Partial set must neither sync nor pop
    if (row.late != '0) begin
      repeat (4) begin
        @(negedge clk_i);
        if (valid_o) begin
          errors++;
          $display("valid_o rose before every participant was valid");
        end
        check_mask("ready_o", ready_o, '0, errors);
      end
      @(posedge clk_i);
      valid_i <= row.vld | row.late;
    end
    wait_pop(ok);
    if (!ok) return;
    seen = ready_o;
    check_mask("ready_o", seen, row.mask, errors);
    exp_q.push_back(row.exp);
    if (row.hold) hold_end = cycle + 8;
    @(posedge clk_i);
    valid_i <= (row.vld | row.late) & ~seen;
    // Reduced flit is visible one cycle after the pop
    @(negedge clk_i);
    if (valid_o !== 1'b1) begin
      errors++;
      $display("valid_o did not rise in the cycle after the inputs were popped");
    end
  endtask

  // Random back-pressure with one LFSR step per ready bit
  always @(posedge clk_i) begin : throttle
    if (rst_i || cycle < hold_end) begin
      ready_i <= 1'b0;
    end else begin
      ready_i <= lfsr[0];
      lfsr    <= lfsr_step(lfsr);
    end
    cycle <= cycle + 1;
  end

  // --------------------
  // Output monitor
  // --------------------

  always @(negedge clk_i) begin : monitor
    if (!rst_i) begin
      // Stalled flit must not move
      if (prev_valid && !prev_ready) begin
        if (!valid_o) begin
          mon_errors++;
          $display("valid_o dropped while the output was stalled");
        end
        check_flit("data_o", data_o, prev_data, mon_errors);
      end
      if (valid_o && !ready_i) check_mask("ready_o", ready_o, '0, mon_errors);
      if (valid_o && ready_i) begin
        if (exp_q.size() == 0) begin
          mon_errors++;
          $display("Output flit %h appeared with no reduction pending", data_o);
        end else begin
          check_flit("data_o", data_o, exp_q.pop_front(), mon_errors);
        end
      end
    end
    prev_valid = valid_o;
    prev_ready = ready_i;
    prev_data  = data_o;
  end

  task automatic close_run();
    $display("Errors: %0d driver, %0d monitor, %0d timeouts", errors, mon_errors, timeouts);
    if (errors + mon_errors + timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  initial begin : main
    bit ok;
    rst_i   <= 1'b1;
    valid_i <= '0;
    data_i  <= '0;
    fill_table();
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    if (valid_o !== 1'b0) begin
      errors++;
      $display("valid_o was not low after reset");
    end
    check_mask("ready_o", ready_o, '0, errors);
    ok = 1'b1;
    for (int r = 0; r < rows.size() && ok; r++) begin
      run_row(rows[r], ok);
    end
    if (ok) wait_idle(ok);
    close_run();
  end

endmodule

/* sources.f */
+incdir+include
logic/red_flit_pkg.sv
logic/red_route_pkg.sv
logic/red_sync_decode.sv
logic/red_op_execute.sv
logic/red_result_stage.sv
logic/red_reduction_top.sv
tb/red_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the reduction stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module red_tb -Mdir obj_dir -f sources.f

out=$(./obj_dir/Vred_tb)
echo "$out"

# Pass only when the testbench printed its pass line
if echo "$out" | grep -qx "Regression passed"; then
  exit 0
else
  exit 1
fi
